// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/instr_ctl.sv
  - logic/imm_gen.sv
  - logic/exec_unit.sv
  - logic/reg_file.sv
  - logic/rv_core.sv
  - target: test
    files:
      - tests/rv_core_tb.sv

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic [rv_pkg::XLEN-1:0] op_a,
    input  logic [rv_pkg::XLEN-1:0] op_b,
    input  rv_pkg::alu_op_e         alu_sel,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic                    br_un,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    br_eq,
    output logic                    br_lt
);

    logic [4:0]              shamt;
    logic [rv_pkg::XLEN-1:0] sum;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign shamt       = op_b[4:0];
    assign sum         = op_a + op_b;
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (alu_sel)
            rv_pkg::alu_add:    result = sum;
            rv_pkg::alu_sub:    result = op_a - op_b;
            rv_pkg::alu_sll:    result = op_a << shamt;
            rv_pkg::alu_slt:    result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            rv_pkg::alu_sltu:   result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            rv_pkg::alu_xor:    result = op_a ^ op_b;
            rv_pkg::alu_srl:    result = op_a >> shamt;
            rv_pkg::alu_sra:    result = $signed(op_a) >>> shamt;
            rv_pkg::alu_or:     result = op_a | op_b;
            rv_pkg::alu_and:    result = op_a & op_b;
            rv_pkg::alu_pass_b: result = op_b;
            // JALR target is always halfword aligned
            rv_pkg::alu_jalr:   result = {sum[rv_pkg::XLEN-1:1], 1'b0};
            default:            result = sum;
        endcase
    end

    // Branch compare works on the raw register values
    assign br_eq = (rs1_data == rs2_data);

    always_comb begin
        if (br_un) begin
            br_lt = rs1_data < rs2_data;
        end else begin
            br_lt = $signed(rs1_data) < $signed(rs2_data);
        end
    end

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  logic [rv_pkg::XLEN-1:0] instruction,
    input  rv_pkg::imm_sel_e        imm_sel,
    output logic [rv_pkg::XLEN-1:0] imm
);

    logic sign;

    // Bit 31 carries the sign in every format
    assign sign = instruction[31];

    always_comb begin
        case (imm_sel)
            rv_pkg::imm_i: imm = {{20{sign}}, instruction[31:20]};
            rv_pkg::imm_s: imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            rv_pkg::imm_b: begin
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            rv_pkg::imm_u: imm = {instruction[31:12], 12'b0};
            rv_pkg::imm_j: begin
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== logic/instr_ctl.sv ====
`timescale 1ns/1ps

module instr_ctl (
    input  logic [rv_pkg::XLEN-1:0] instruction,
    input  logic                    br_eq,
    input  logic                    br_lt,
    output rv_pkg::ctl_t            ctl
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            alt;
    logic            shift_ok;
    logic            reg_ok;
    logic            br_valid;
    logic            br_taken;

    function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic sel_alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000: begin
                if (sel_alt) op = rv_pkg::alu_sub;
                else op = rv_pkg::alu_add;
            end
            3'b001: op = rv_pkg::alu_sll;
            3'b010: op = rv_pkg::alu_slt;
            3'b011: op = rv_pkg::alu_sltu;
            3'b100: op = rv_pkg::alu_xor;
            3'b101: begin
                if (sel_alt) op = rv_pkg::alu_sra;
                else op = rv_pkg::alu_srl;
            end
            3'b110: op = rv_pkg::alu_or;
            default: op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = rv_pkg::opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign alt    = (funct7 == rv_pkg::F7_ALT);

    // Alternate funct7 only legal on SRAI/SRA and SUB
    assign shift_ok = (funct7 == rv_pkg::F7_BASE) || (alt && funct3 == 3'b101);
    assign reg_ok   = shift_ok || (alt && funct3 == 3'b000);

    always_comb begin
        br_valid = 1'b1;
        case (funct3)
            3'b000: br_taken = br_eq;
            3'b001: br_taken = ~br_eq;
            3'b100, 3'b110: br_taken = br_lt;
            3'b101, 3'b111: br_taken = ~br_lt;
            default: begin
                br_taken = 1'b0;
                br_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        // No-op unless a supported encoding is matched
        ctl.a_sel   = rv_pkg::A_RS1;
        ctl.b_sel   = rv_pkg::B_RS2;
        ctl.alu_sel = rv_pkg::alu_add;
        ctl.mem_wr  = 1'b0;
        ctl.reg_wen = 1'b0;
        ctl.imm_sel = rv_pkg::imm_i;
        ctl.br_un   = 1'b0;
        ctl.pc_sel  = rv_pkg::PC_SEQ;
        ctl.wb_sel  = rv_pkg::wb_alu;
        case (opcode)
            rv_pkg::op_lui: begin
                ctl.b_sel   = rv_pkg::B_IMM;
                ctl.alu_sel = rv_pkg::alu_pass_b;
                ctl.imm_sel = rv_pkg::imm_u;
                ctl.reg_wen = 1'b1;
            end
            rv_pkg::op_auipc: begin
                ctl.a_sel   = rv_pkg::A_PC;
                ctl.b_sel   = rv_pkg::B_IMM;
                ctl.imm_sel = rv_pkg::imm_u;
                ctl.reg_wen = 1'b1;
            end
            rv_pkg::op_jal: begin
                ctl.a_sel   = rv_pkg::A_PC;
                ctl.b_sel   = rv_pkg::B_IMM;
                ctl.imm_sel = rv_pkg::imm_j;
                ctl.reg_wen = 1'b1;
                ctl.pc_sel  = rv_pkg::PC_ALU;
                ctl.wb_sel  = rv_pkg::wb_pc4;
            end
            rv_pkg::op_jalr: begin
                if (funct3 == 3'b000) begin
                    ctl.b_sel   = rv_pkg::B_IMM;
                    ctl.alu_sel = rv_pkg::alu_jalr;
                    ctl.reg_wen = 1'b1;
                    ctl.pc_sel  = rv_pkg::PC_ALU;
                    ctl.wb_sel  = rv_pkg::wb_pc4;
                end
            end
            rv_pkg::op_branch: begin
                if (br_valid) begin
                    ctl.a_sel   = rv_pkg::A_PC;
                    ctl.b_sel   = rv_pkg::B_IMM;
                    ctl.imm_sel = rv_pkg::imm_b;
                    // BLTU and BGEU have funct3[1] set
                    ctl.br_un   = funct3[1];
                    ctl.pc_sel  = br_taken;
                end
            end
            rv_pkg::op_load: begin
                if (funct3 == 3'b010) begin
                    ctl.b_sel   = rv_pkg::B_IMM;
                    ctl.reg_wen = 1'b1;
                    ctl.wb_sel  = rv_pkg::wb_mem;
                end
            end
            rv_pkg::op_store: begin
                if (funct3 == 3'b010) begin
                    ctl.b_sel   = rv_pkg::B_IMM;
                    ctl.imm_sel = rv_pkg::imm_s;
                    ctl.mem_wr  = 1'b1;
                end
            end
            rv_pkg::op_imm: begin
                if ((funct3 != 3'b001 && funct3 != 3'b101) || shift_ok) begin
                    ctl.b_sel   = rv_pkg::B_IMM;
                    ctl.alu_sel = alu_decode(funct3, alt && funct3 == 3'b101);
                    ctl.reg_wen = 1'b1;
                end
            end
            rv_pkg::op_reg: begin
                if (reg_ok) begin
                    ctl.alu_sel = alu_decode(funct3, alt);
                    ctl.reg_wen = 1'b1;
                end
            end
            default: begin
                ctl.reg_wen = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [rv_pkg::REG_AW-1:0] rs1_addr,
    input  logic [rv_pkg::REG_AW-1:0] rs2_addr,
    input  logic [rv_pkg::REG_AW-1:0] rd_addr,
    input  logic [rv_pkg::XLEN-1:0]   rd_data,
    input  logic                      wen,
    output logic [rv_pkg::XLEN-1:0]   rs1_data,
    output logic [rv_pkg::XLEN-1:0]   rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != '0) begin
            // x0 is never written, so it stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    input  logic [rv_pkg::XLEN-1:0] imem_data,
    output rv_pkg::dmem_req_t       dmem_req,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata
);

    rv_pkg::ctl_t            ctl;
    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] wb_data;
    logic                    br_eq;
    logic                    br_lt;

    assign pc_plus4 = pc + rv_pkg::PC_STEP;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::RESET_PC;
        end else if (ctl.pc_sel == rv_pkg::PC_ALU) begin
            pc <= alu_result;
        end else begin
            pc <= pc_plus4;
        end
    end

    assign imem_addr = pc;

    instr_ctl ctl_i (
        .instruction (imem_data),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .ctl         (ctl)
    );

    imm_gen imm_i (
        .instruction (imem_data),
        .imm_sel     (ctl.imm_sel),
        .imm         (imm)
    );

    reg_file rf_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (imem_data[19:15]),
        .rs2_addr (imem_data[24:20]),
        .rd_addr  (imem_data[11:7]),
        .rd_data  (wb_data),
        .wen      (ctl.reg_wen),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Operand selection
    assign op_a = (ctl.a_sel == rv_pkg::A_PC) ? pc : rs1_data;
    assign op_b = (ctl.b_sel == rv_pkg::B_IMM) ? imm : rs2_data;

    exec_unit exec_i (
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_sel  (ctl.alu_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .br_un    (ctl.br_un),
        .result   (alu_result),
        .br_eq    (br_eq),
        .br_lt    (br_lt)
    );

    always_comb begin
        case (ctl.wb_sel)
            rv_pkg::wb_mem: wb_data = dmem_rdata;
            rv_pkg::wb_alu: wb_data = alu_result;
            rv_pkg::wb_pc4: wb_data = pc_plus4;
            default:        wb_data = alu_result;
        endcase
    end

    // No stores land while in reset
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;
    assign dmem_req.we    = ctl.mem_wr & ~reset;

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS);

    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam logic [XLEN-1:0] PC_STEP  = 4;

    // Operand and next-PC select values
    localparam logic A_RS1  = 1'b0;
    localparam logic A_PC   = 1'b1;
    localparam logic B_RS2  = 1'b0;
    localparam logic B_IMM  = 1'b1;
    localparam logic PC_SEQ = 1'b0;
    localparam logic PC_ALU = 1'b1;

    // funct7 encodings for the ALU groups
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10,
        // Add with bit 0 cleared, for the JALR target
        alu_jalr   = 4'd11
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_sel_e;

    typedef enum logic [1:0] {
        wb_mem = 2'd0,
        wb_alu = 2'd1,
        wb_pc4 = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic     a_sel;
        logic     b_sel;
        alu_op_e  alu_sel;
        logic     mem_wr;
        logic     reg_wen;
        imm_sel_e imm_sel;
        logic     br_un;
        logic     pc_sel;
        wb_sel_e  wb_sel;
    } ctl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } dmem_req_t;

endpackage

// ==== rv_core.f ====
logic/rv_pkg.sv
logic/instr_ctl.sv
logic/imm_gen.sv
logic/exec_unit.sv
logic/reg_file.sv
logic/rv_core.sv
tests/rv_core_tb.sv

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    typedef logic [rv_pkg::XLEN-1:0] word_t;

    logic              clk;
    logic              reset;
    word_t             imem_addr;
    word_t             imem_data;
    rv_pkg::dmem_req_t dmem_req;
    word_t             dmem_rdata;

    word_t      mem [64];
    word_t      ref_mem [64];
    word_t      ref_regs [32];
    word_t      ref_pc;
    word_t      prog [$];
    string      prog_test [$];
    int         prog_len;
    int         step_idx;
    logic       done;
    logic [31:0] lfsr;

    rv_core dut_i (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    always #50 clk = ~clk;

    // Data memory indexed by address bits 7 to 2
    assign dmem_rdata = mem[dmem_req.addr[7:2]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            mem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [4:0] r;
        r = 5'(take_bits(5));
        if (r == 5'd0) begin
            r = 5'd1;
        end
        return r;
    endfunction

    // Word offset that stays inside the 256-byte data memory
    function automatic logic [11:0] word_off();
        return 12'(take_bits(6) << 2);
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                    input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
    endfunction

    task automatic emit(input string test, input word_t ins);
        prog.push_back(ins);
        prog_test.push_back(test);
    endtask

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [19:0] uimm;
        logic [2:0]  br_f3 [6];
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        // Random contents in every register including sign bits
        for (int r = 1; r < 32; r++) begin
            emit("seed", enc_u(20'(take_bits(20)), 5'(r), rv_pkg::op_lui));
            emit("seed", enc_i(12'(take_bits(12)), 5'(r), 3'b000, 5'(r), rv_pkg::op_imm));
        end
        for (int i = 0; i < 48; i++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            f3  = 3'(take_bits(3));
            if (take_bits(1) != 0) begin
                f7 = 7'b0000000;
                if ((f3 == 3'b000 || f3 == 3'b101) && take_bits(1) != 0) begin
                    f7 = 7'b0100000;
                end
                emit("alu_reg", enc_r(f7, rs2, rs1, f3, rd));
            end else begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    f7 = (f3 == 3'b101 && take_bits(1) != 0) ? 7'b0100000 : 7'b0000000;
                    imm = {f7, 5'(take_bits(5))};
                end else begin
                    imm = 12'(take_bits(12));
                end
                emit("alu_imm", enc_i(imm, rs1, f3, rd, rv_pkg::op_imm));
            end
            emit("alu_store", enc_s(word_off(), rd, 5'd0));
        end
        for (int i = 0; i < 4; i++) begin
            rd = rand_reg();
            emit("lui", enc_u(20'(take_bits(20)), rd, rv_pkg::op_lui));
            emit("lui_store", enc_s(word_off(), rd, 5'd0));
            rd = rand_reg();
            emit("auipc", enc_u(20'(take_bits(20)), rd, rv_pkg::op_auipc));
            emit("auipc_store", enc_s(word_off(), rd, 5'd0));
        end
        // Rounds of six: equal, negative rs1 against flipped sign, positive rs1, random
        for (int i = 0; i < 24; i++) begin
            rs1  = rand_reg();
            rs2  = rand_reg();
            uimm = 20'(take_bits(20));
            if (i / 6 == 1) begin
                uimm[19] = 1'b1;
            end else if (i / 6 == 2) begin
                uimm[19] = 1'b0;
            end
            emit("branch_setup", enc_u(uimm, rs1, rv_pkg::op_lui));
            if (i < 6) begin
                rs2 = rs1;
            end else begin
                if (rs2 == rs1) begin
                    rs2 = (rs1 == 5'd31) ? 5'd1 : rs1 + 5'd1;
                end
                if (i < 18) begin
                    uimm[19] = ~uimm[19];
                end else begin
                    uimm = 20'(take_bits(20));
                end
                emit("branch_setup", enc_u(uimm, rs2, rv_pkg::op_lui));
            end
            emit("branch", enc_b(13'(take_bits(11) << 2), rs2, rs1, br_f3[i % 6]));
        end
        for (int i = 0; i < 6; i++) begin
            rd = rand_reg();
            emit("jal", enc_j(21'(take_bits(19) << 2), rd));
            emit("jal_link", enc_s(word_off(), rd, 5'd0));
            // Base ends in 01 so the cleared bit 0 gives a word target
            rs1 = rand_reg();
            emit("jalr_base", enc_i({10'(take_bits(10)), 2'b01}, 5'd0, 3'b000, rs1,
                                    rv_pkg::op_imm));
            rd = rand_reg();
            emit("jalr", enc_i(12'(take_bits(10) << 2), rs1, 3'b000, rd, rv_pkg::op_jalr));
            emit("jalr_link", enc_s(word_off(), rd, 5'd0));
        end
        for (int i = 0; i < 8; i++) begin
            imm = word_off();
            rd  = rand_reg();
            emit("sw", enc_s(imm, rand_reg(), 5'd0));
            emit("lw", enc_i(imm, 5'd0, 3'b010, rd, rv_pkg::op_load));
            emit("lw_store", enc_s(word_off(), rd, 5'd0));
        end
        emit("x0_write", enc_i(12'(take_bits(12)), 5'd0, 3'b000, 5'd0, rv_pkg::op_imm));
        emit("x0_load", enc_i(word_off(), 5'd0, 3'b010, 5'd0, rv_pkg::op_load));
        emit("x0_store", enc_s(word_off(), 5'd0, 5'd0));
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA model of one instruction on the testbench's own state
    function automatic void ref_step(input word_t ins, output word_t next_pc,
                                     output rv_pkg::dmem_req_t req);
        logic [2:0] f3;
        logic [4:0] rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        word_t      addr;
        word_t      wval;
        logic       wr;
        logic       taken;
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = ref_pc + 32'd4;
        req  = '0;
        wr   = 1'b0;
        wval = '0;
        case (ins[6:0])
            rv_pkg::op_lui: begin
                wr   = 1'b1;
                wval = imm_u;
            end
            rv_pkg::op_auipc: begin
                wr   = 1'b1;
                wval = ref_pc + imm_u;
            end
            rv_pkg::op_jal: begin
                wr      = 1'b1;
                wval    = ref_pc + 32'd4;
                next_pc = ref_pc + imm_j;
            end
            rv_pkg::op_jalr: begin
                wr      = 1'b1;
                wval    = ref_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            rv_pkg::op_branch: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    3'b110: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    next_pc = ref_pc + imm_b;
                end
            end
            rv_pkg::op_load: begin
                addr = a + imm_i;
                wr   = 1'b1;
                wval = ref_mem[addr[7:2]];
            end
            rv_pkg::op_store: begin
                addr      = a + imm_s;
                req.we    = 1'b1;
                req.addr  = addr;
                req.wdata = b;
                ref_mem[addr[7:2]] = b;
            end
            rv_pkg::op_imm: begin
                wr   = 1'b1;
                wval = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
            end
            default: begin
                wr   = 1'b1;
                wval = alu_ref(f3, ins[30], a, b);
            end
        endcase
        if (wr && rd != 5'd0) begin
            ref_regs[rd] = wval;
        end
    endfunction

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "Stopping at first mismatch");
    endtask

    task automatic compare_addr(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_dmem(input string name, input rv_pkg::dmem_req_t exp,
                                input rv_pkg::dmem_req_t act);
        if (act.we !== exp.we) begin
            $display("Fail %s we expected %b actual %b", name, exp.we, act.we);
            stop_run();
        end
        // Address and data only matter on a store
        if (exp.we && (act.addr !== exp.addr || act.wdata !== exp.wdata)) begin
            $display("Fail %s expected %h/%h actual %h/%h", name, exp.addr, exp.wdata,
                     act.addr, act.wdata);
            stop_run();
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        // A store held during reset must not reach memory
        imem_data = enc_s(12'd0, 5'd0, 5'd0);
        done      = 1'b0;
        step_idx  = 0;
        lfsr      = 32'd42;
        ref_pc    = rv_pkg::RESET_PC;
        // Fill pattern built from each word's own address
        for (int i = 0; i < 64; i++) begin
            mem[i]     = 32'hd00d_0000 | (i << 2);
            ref_mem[i] = 32'hd00d_0000 | (i << 2);
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        build_program();
        prog_len = prog.size();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        foreach (prog[i]) begin
            imem_data = prog[i];
            @(posedge clk);
            #1;
        end
        imem_data = 32'h0000_0013;
        wait (done);
        $display("Testbench passed");
        $finish;
    end

    // Checks at the falling edge where everything has settled
    initial begin
        word_t             next_pc;
        rv_pkg::dmem_req_t exp_req;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (reset) begin
                exp_req = '0;
                compare_addr("reset_pc", rv_pkg::RESET_PC, imem_addr);
                compare_dmem("reset", exp_req, dmem_req);
            end else if (step_idx < prog_len) begin
                compare_addr({prog_test[step_idx], "_pc"}, ref_pc, imem_addr);
                ref_step(prog[step_idx], next_pc, exp_req);
                compare_dmem(prog_test[step_idx], exp_req, dmem_req);
                ref_pc = next_pc;
                step_idx++;
            end else if (!done) begin
                compare_addr("final_pc", ref_pc, imem_addr);
                done = 1'b1;
            end
        end
    end

    initial begin
        wait (prog_len != 0);
        #(2 * prog_len * 100 + 8 * 100);
        $display("Watchdog expired before all instructions were checked");
        $display("Testbench failed");
        $fatal(1, "Run timed out");
    end

endmodule
